/* files.f */
mm_pkg.sv
mm_regs.sv
mm_sequencer.sv
mm_dma_rd.sv
mm_mac_array.sv
mm_dma_wr.sv
mm_top.sv
tb_mm_mem.sv
tb_mm_top.sv

/* mm_dma_rd.sv */
`timescale 1ns/1ps

module mm_dma_rd #(
    parameter int MAT_DIM = 4
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          fetch_start,
    input  mm_pkg::addr_t base,
    // Wishbone classic read master
    output logic          cyc,
    output logic          stb,
    output mm_pkg::addr_t adr,
    input  mm_pkg::word_t dat_r,
    input  logic          ack,
    // Fetched matrix, element k at bits k*8 upwards
    output logic [MAT_DIM*MAT_DIM*$bits(mm_pkg::elem_t)-1:0] matrix,
    output logic          fetch_done
);
    import mm_pkg::*;

    localparam int N  = MAT_DIM * MAT_DIM;
    localparam int EW = $bits(elem_t);
    localparam int IW = (N > 1) ? $clog2(N) : 1;

    logic          busy;
    logic [IW-1:0] idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            cyc        <= 1'b0;
            stb        <= 1'b0;
            idx        <= '0;
            fetch_done <= 1'b0;
        end else begin
            fetch_done <= 1'b0;
            if (fetch_start && !busy) begin
                busy <= 1'b1;
                cyc  <= 1'b1;
                stb  <= 1'b1;
                idx  <= '0;
            end else if (cyc && ack) begin
                // Bus goes idle for a cycle between accesses
                cyc <= 1'b0;
                stb <= 1'b0;
                if (idx == IW'(N - 1)) begin
                    busy       <= 1'b0;
                    fetch_done <= 1'b1;
                end else begin
                    idx <= idx + 1'b1;
                end
            end else if (busy && !cyc) begin
                cyc <= 1'b1;
                stb <= 1'b1;
            end
        end
    end

    // Address and element buffer
    always_ff @(posedge clk) begin
        if (fetch_start && !busy) begin
            adr <= base;
        end else if (cyc && ack) begin
            adr                     <= adr + addr_t'(4);
            matrix[idx*EW +: EW]    <= elem_t'(dat_r[EW-1:0]);
        end
    end

endmodule

/* mm_dma_wr.sv */
`timescale 1ns/1ps

module mm_dma_wr #(
    parameter int MAT_DIM = 4
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          run_start,
    input  mm_pkg::addr_t base,
    // Result stream from the compute stage
    input  logic          elem_valid,
    output logic          elem_ready,
    input  mm_pkg::acc_t  elem_data,
    // Wishbone classic write master
    output logic          cyc,
    output logic          stb,
    output mm_pkg::addr_t adr,
    output mm_pkg::word_t dat_w,
    input  logic          ack,
    output logic          store_done
);
    import mm_pkg::*;

    localparam int N  = MAT_DIM * MAT_DIM;
    localparam int IW = (N > 1) ? $clog2(N) : 1;

    logic          running;
    logic [IW-1:0] cnt;

    // One element in flight at a time
    assign elem_ready = running && !cyc;

    always_ff @(posedge clk) begin
        if (rst) begin
            running    <= 1'b0;
            cyc        <= 1'b0;
            stb        <= 1'b0;
            cnt        <= '0;
            store_done <= 1'b0;
        end else begin
            store_done <= 1'b0;
            if (run_start && !running) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (elem_valid && elem_ready) begin
                cyc <= 1'b1;
                stb <= 1'b1;
            end else if (cyc && ack) begin
                cyc <= 1'b0;
                stb <= 1'b0;
                if (cnt == IW'(N - 1)) begin
                    running    <= 1'b0;
                    store_done <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // Element k goes to base + 4k
    always_ff @(posedge clk) begin
        if (elem_valid && elem_ready) begin
            adr   <= base + (addr_t'(cnt) << 2);
            dat_w <= word_t'(elem_data);
        end
    end

endmodule

/* mm_mac_array.sv */
`timescale 1ns/1ps

module mm_mac_array #(
    parameter int MAT_DIM = 4
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         run_start,
    input  logic [MAT_DIM*MAT_DIM*$bits(mm_pkg::elem_t)-1:0] a_mat,
    input  logic [MAT_DIM*MAT_DIM*$bits(mm_pkg::elem_t)-1:0] b_mat,
    // Result stream toward the writer
    output logic         elem_valid,
    input  logic         elem_ready,
    output mm_pkg::acc_t elem_data
);
    import mm_pkg::*;

    localparam int EW = $bits(elem_t);
    localparam int DW = (MAT_DIM > 1) ? $clog2(MAT_DIM) : 1;

    logic          active;
    logic [DW-1:0] row;
    logic [DW-1:0] col;
    logic          load;
    acc_t          dot;

    // Dot product of row `row` of A and column `col` of B
    always_comb begin
        elem_t a_k;
        elem_t b_k;
        dot = '0;
        for (int k = 0; k < MAT_DIM; k++) begin
            a_k = elem_t'(a_mat[(int'(row) * MAT_DIM + k) * EW +: EW]);
            b_k = elem_t'(b_mat[(k * MAT_DIM + int'(col)) * EW +: EW]);
            dot = dot + acc_t'(a_k) * acc_t'(b_k);
        end
    end

    // Load whenever the output register is empty or being taken
    assign load = active && (!elem_valid || elem_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            active     <= 1'b0;
            row        <= '0;
            col        <= '0;
            elem_valid <= 1'b0;
        end else begin
            if (run_start && !active) begin
                active <= 1'b1;
                row    <= '0;
                col    <= '0;
            end else if (load) begin
                if (col == DW'(MAT_DIM - 1)) begin
                    col <= '0;
                    if (row == DW'(MAT_DIM - 1)) begin
                        active <= 1'b0;
                    end else begin
                        row <= row + 1'b1;
                    end
                end else begin
                    col <= col + 1'b1;
                end
            end

            if (load) begin
                elem_valid <= 1'b1;
            end else if (elem_ready) begin
                elem_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            elem_data <= dot;
        end
    end

endmodule

/* mm_pkg.sv */
package mm_pkg;

    // Bus word and byte address
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // Matrix element (low byte of a memory word) and result element
    typedef logic signed [7:0]  elem_t;
    typedef logic signed [31:0] acc_t;

    // Register byte offset on the slave port
    typedef logic [4:0] reg_adr_t;

    localparam reg_adr_t REG_CTRL   = 5'h00;
    localparam reg_adr_t REG_A_ADDR = 5'h04;
    localparam reg_adr_t REG_B_ADDR = 5'h08;
    localparam reg_adr_t REG_C_ADDR = 5'h0C;

    // Bit positions in the control word
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_DONE_BIT  = 1;
    localparam int CTRL_IDLE_BIT  = 2;

    localparam int DEFAULT_MAT_DIM = 4;

    // Sequencer states
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        RUN,
        DONE
    } seq_state_t;

endpackage

/* mm_regs.sv */
`timescale 1ns/1ps

module mm_regs (
    input  logic             clk,
    input  logic             rst,
    // Wishbone classic slave
    input  logic             wbs_cyc,
    input  logic             wbs_stb,
    input  logic             wbs_we,
    input  mm_pkg::reg_adr_t wbs_adr,
    input  mm_pkg::word_t    wbs_dat_w,
    output mm_pkg::word_t    wbs_dat_r,
    output logic             wbs_ack,
    // Live status from the sequencer
    input  logic             idle,
    input  logic             done,
    // Programmed values
    output logic             start,
    output mm_pkg::addr_t    a_base,
    output mm_pkg::addr_t    b_base,
    output mm_pkg::addr_t    c_base
);
    import mm_pkg::*;

    logic  access;
    word_t rd_data;

    // First cycle of an access, ack follows on the next cycle
    assign access = wbs_cyc && wbs_stb && !wbs_ack;

    always_comb begin
        rd_data = '0;
        case (wbs_adr)
            REG_CTRL: begin
                rd_data[CTRL_START_BIT] = start;
                rd_data[CTRL_DONE_BIT]  = done;
                rd_data[CTRL_IDLE_BIT]  = idle;
            end
            REG_A_ADDR: rd_data = a_base;
            REG_B_ADDR: rd_data = b_base;
            REG_C_ADDR: rd_data = c_base;
            default:    rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbs_ack <= 1'b0;
            start   <= 1'b0;
        end else begin
            wbs_ack <= access;
            // Only the start bit is writable in the control word
            if (access && wbs_we && wbs_adr == REG_CTRL) begin
                start <= wbs_dat_w[CTRL_START_BIT];
            end
        end
    end

    // Read data and base addresses
    always_ff @(posedge clk) begin
        if (access) begin
            wbs_dat_r <= rd_data;
        end
        if (access && wbs_we) begin
            case (wbs_adr)
                REG_A_ADDR: a_base <= wbs_dat_w;
                REG_B_ADDR: b_base <= wbs_dat_w;
                REG_C_ADDR: c_base <= wbs_dat_w;
                default: ;
            endcase
        end
    end

endmodule

/* mm_sequencer.sv */
`timescale 1ns/1ps

module mm_sequencer (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic a_done,
    input  logic b_done,
    input  logic store_done,
    output logic fetch_start,
    output logic run_start,
    output logic idle,
    output logic irq
);
    import mm_pkg::*;

    seq_state_t state;
    logic       start_q;
    logic       a_seen;
    logic       b_seen;
    logic       a_got;
    logic       b_got;

    // Reader done pulses may arrive in either order
    assign a_got = a_seen || a_done;
    assign b_got = b_seen || b_done;

    assign idle = (state == IDLE);
    assign irq  = (state == DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            start_q     <= 1'b0;
            a_seen      <= 1'b0;
            b_seen      <= 1'b0;
            fetch_start <= 1'b0;
            run_start   <= 1'b0;
        end else begin
            start_q     <= start;
            fetch_start <= 1'b0;
            run_start   <= 1'b0;
            case (state)
                IDLE: begin
                    if (start && !start_q) begin
                        fetch_start <= 1'b1;
                        a_seen      <= 1'b0;
                        b_seen      <= 1'b0;
                        state       <= FETCH;
                    end
                end
                FETCH: begin
                    a_seen <= a_got;
                    b_seen <= b_got;
                    if (a_got && b_got) begin
                        run_start <= 1'b1;
                        state     <= RUN;
                    end
                end
                RUN: begin
                    if (store_done) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    // Hold the interrupt until software clears start
                    if (!start) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* mm_top.sv */
`timescale 1ns/1ps

module mm_top #(
    parameter int MAT_DIM = mm_pkg::DEFAULT_MAT_DIM
) (
    input  logic             clk,
    input  logic             rst,
    // Register slave
    input  logic             wbs_cyc,
    input  logic             wbs_stb,
    input  logic             wbs_we,
    input  mm_pkg::reg_adr_t wbs_adr,
    input  mm_pkg::word_t    wbs_dat_w,
    output mm_pkg::word_t    wbs_dat_r,
    output logic             wbs_ack,
    // Read master for A
    output logic             a_cyc,
    output logic             a_stb,
    output mm_pkg::addr_t    a_adr,
    input  mm_pkg::word_t    a_dat_r,
    input  logic             a_ack,
    // Read master for B
    output logic             b_cyc,
    output logic             b_stb,
    output mm_pkg::addr_t    b_adr,
    input  mm_pkg::word_t    b_dat_r,
    input  logic             b_ack,
    // Write master for C
    output logic             c_cyc,
    output logic             c_stb,
    output mm_pkg::addr_t    c_adr,
    output mm_pkg::word_t    c_dat_w,
    input  logic             c_ack,
    output logic             interrupt
);
    import mm_pkg::*;

    localparam int MW = MAT_DIM * MAT_DIM * $bits(elem_t);

    logic          start;
    logic          idle;
    addr_t         a_base;
    addr_t         b_base;
    addr_t         c_base;
    logic          fetch_start;
    logic          a_done;
    logic          b_done;
    logic          run_start;
    logic          store_done;
    logic [MW-1:0] a_mat;
    logic [MW-1:0] b_mat;
    logic          elem_valid;
    logic          elem_ready;
    acc_t          elem_data;

    mm_regs u_regs (
        .clk(clk), .rst(rst),
        .wbs_cyc(wbs_cyc), .wbs_stb(wbs_stb), .wbs_we(wbs_we),
        .wbs_adr(wbs_adr), .wbs_dat_w(wbs_dat_w), .wbs_dat_r(wbs_dat_r),
        .wbs_ack(wbs_ack),
        .idle(idle), .done(interrupt), .start(start),
        .a_base(a_base), .b_base(b_base), .c_base(c_base)
    );

    mm_sequencer u_seq (
        .clk(clk), .rst(rst), .start(start),
        .a_done(a_done), .b_done(b_done), .store_done(store_done),
        .fetch_start(fetch_start), .run_start(run_start),
        .idle(idle), .irq(interrupt)
    );

    // A and B are fetched concurrently
    mm_dma_rd #(.MAT_DIM(MAT_DIM)) rd_a (
        .clk(clk), .rst(rst), .fetch_start(fetch_start), .base(a_base),
        .cyc(a_cyc), .stb(a_stb), .adr(a_adr), .dat_r(a_dat_r), .ack(a_ack),
        .matrix(a_mat), .fetch_done(a_done)
    );

    mm_dma_rd #(.MAT_DIM(MAT_DIM)) rd_b (
        .clk(clk), .rst(rst), .fetch_start(fetch_start), .base(b_base),
        .cyc(b_cyc), .stb(b_stb), .adr(b_adr), .dat_r(b_dat_r), .ack(b_ack),
        .matrix(b_mat), .fetch_done(b_done)
    );

    mm_mac_array #(.MAT_DIM(MAT_DIM)) u_mac (
        .clk(clk), .rst(rst), .run_start(run_start),
        .a_mat(a_mat), .b_mat(b_mat),
        .elem_valid(elem_valid), .elem_ready(elem_ready), .elem_data(elem_data)
    );

    mm_dma_wr #(.MAT_DIM(MAT_DIM)) u_wr (
        .clk(clk), .rst(rst), .run_start(run_start), .base(c_base),
        .elem_valid(elem_valid), .elem_ready(elem_ready), .elem_data(elem_data),
        .cyc(c_cyc), .stb(c_stb), .adr(c_adr), .dat_w(c_dat_w), .ack(c_ack),
        .store_done(store_done)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary -j 0 --top-module tb_mm_top -f files.f; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_mm_top 2>&1)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Verification passed"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

/* tb_mm_mem.sv */
`timescale 1ns/1ps

module tb_mm_mem #(
    parameter int MEM_WORDS = 256,
    parameter int SEED      = 1
) (
    input  logic          clk,
    input  logic          rst,
    // Read port for A
    input  logic          a_cyc,
    input  logic          a_stb,
    input  mm_pkg::addr_t a_adr,
    output mm_pkg::word_t a_dat_r,
    output logic          a_ack,
    // Read port for B
    input  logic          b_cyc,
    input  logic          b_stb,
    input  mm_pkg::addr_t b_adr,
    output mm_pkg::word_t b_dat_r,
    output logic          b_ack,
    // Write port for C
    input  logic          c_cyc,
    input  logic          c_stb,
    input  mm_pkg::addr_t c_adr,
    input  mm_pkg::word_t c_dat_w,
    output logic          c_ack,
    // Preload port, used only while the DUT is idle
    input  logic          ld_en,
    input  mm_pkg::addr_t ld_adr,
    input  mm_pkg::word_t ld_dat
);
    import mm_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    word_t      mem [MEM_WORDS];
    logic [2:0] req;
    logic [2:0] ack_q;
    logic [2:0] busy;
    logic [1:0] wait_cnt [3];
    integer     seed = SEED;

    // Port 0 is A, port 1 is B, port 2 is C
    assign req   = {c_cyc && c_stb, b_cyc && b_stb, a_cyc && a_stb};
    assign a_ack = ack_q[0];
    assign b_ack = ack_q[1];
    assign c_ack = ack_q[2];

    // Word index comes from the byte address
    assign a_dat_r = mem[a_adr[AW+1:2]];
    assign b_dat_r = mem[b_adr[AW+1:2]];

    always @(posedge clk) begin
        logic [1:0] dly;
        if (rst) begin
            ack_q <= '0;
            busy  <= '0;
        end else begin
            for (int p = 0; p < 3; p++) begin
                ack_q[p] <= 1'b0;
                if (req[p] && !ack_q[p]) begin
                    if (!busy[p]) begin
                        // Fresh delay of 0 to 3 cycles for every access
                        dly = 2'($random(seed));
                        if (dly == 2'd0) begin
                            ack_q[p] <= 1'b1;
                        end else begin
                            busy[p]     <= 1'b1;
                            wait_cnt[p] <= dly - 2'd1;
                        end
                    end else if (wait_cnt[p] == 2'd0) begin
                        busy[p]  <= 1'b0;
                        ack_q[p] <= 1'b1;
                    end else begin
                        wait_cnt[p] <= wait_cnt[p] - 2'd1;
                    end
                end
            end
        end
        // Write lands on the edge where the master sees ack
        if (ld_en) begin
            mem[ld_adr[AW+1:2]] <= ld_dat;
        end else if (ack_q[2] && c_cyc) begin
            mem[c_adr[AW+1:2]] <= c_dat_w;
        end
    end

endmodule

/* tb_mm_top.sv */
`timescale 1ns/1ps

module tb_mm_top;
    import mm_pkg::*;

    localparam int DIM          = DEFAULT_MAT_DIM;
    localparam int N            = DIM * DIM;
    localparam int MEM_WORDS    = 256;
    localparam int NUM_SLOTS    = MEM_WORDS / N;
    localparam int SEED         = 32'h329105c8;
    localparam int NUM_RUNS     = 4;
    localparam int ACK_LIMIT    = 16;
    localparam int RUN_LIMIT    = 4000;
    localparam int FALL_LIMIT   = 2;
    localparam int QUIET_CYCLES = 60;

    logic     clk;
    logic     rst;
    logic     wbs_cyc;
    logic     wbs_stb;
    logic     wbs_we;
    reg_adr_t wbs_adr;
    word_t    wbs_dat_w;
    word_t    wbs_dat_r;
    logic     wbs_ack;
    logic     a_cyc;
    logic     a_stb;
    addr_t    a_adr;
    word_t    a_dat_r;
    logic     a_ack;
    logic     b_cyc;
    logic     b_stb;
    addr_t    b_adr;
    word_t    b_dat_r;
    logic     b_ack;
    logic     c_cyc;
    logic     c_stb;
    addr_t    c_adr;
    word_t    c_dat_w;
    logic     c_ack;
    logic     interrupt;
    logic     ld_en;
    addr_t    ld_adr;
    word_t    ld_dat;

    // Expected memory contents and the current operands
    word_t    shadow [MEM_WORDS];
    elem_t    a_elem [N];
    elem_t    b_elem [N];
    integer   seed = SEED;

    mm_top #(.MAT_DIM(DIM)) DUT (.*);

    tb_mm_mem #(.MEM_WORDS(MEM_WORDS), .SEED(SEED)) u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Every master raises and drops stb together with cyc
    always @(posedge clk) begin
        if (!rst) begin
            check_bit("a_stb", a_stb, a_cyc);
            check_bit("b_stb", b_stb, b_cyc);
            check_bit("c_stb", c_stb, c_cyc);
        end
    end

    task automatic fail_run(input string why);
        $display("%0t: %s", $time, why);
        $display("Verification failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            fail_run("word compare mismatch");
        end
    endtask

    task automatic check_acc(input string name, input acc_t got, input acc_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
            fail_run("result compare mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
            fail_run("signal compare mismatch");
        end
    endtask

    // Mixes every address bit into the background word
    function automatic word_t fill_word(input int idx);
        return (word_t'(idx) * 32'h9e37_79b1) ^ 32'hc3a5_5a3c;
    endfunction

    function automatic word_t ctrl_word(input logic start, input logic done, input logic idle);
        word_t w;
        w = '0;
        w[CTRL_START_BIT] = start;
        w[CTRL_DONE_BIT]  = done;
        w[CTRL_IDLE_BIT]  = idle;
        return w;
    endfunction

    // C[i][j] is the signed sum over m of A[i][m] * B[m][j]
    function automatic acc_t model_elem(input int k);
        int   row;
        int   col;
        acc_t sum;
        row = k / DIM;
        col = k % DIM;
        sum = '0;
        for (int m = 0; m < DIM; m++) begin
            sum += acc_t'(a_elem[row * DIM + m]) * acc_t'(b_elem[m * DIM + col]);
        end
        return sum;
    endfunction

    task automatic reg_access(input logic we, input reg_adr_t adr, input word_t wdata,
                              output word_t rdata);
        int cycles;
        @(posedge clk);
        wbs_cyc   <= 1'b1;
        wbs_stb   <= 1'b1;
        wbs_we    <= we;
        wbs_adr   <= adr;
        wbs_dat_w <= wdata;
        cycles = 0;
        @(posedge clk);
        while (wbs_ack !== 1'b1) begin
            cycles++;
            if (cycles > ACK_LIMIT) begin
                fail_run("register slave gave no ack");
            end
            @(posedge clk);
        end
        if (cycles != 1) begin
            fail_run("register slave ack did not come one cycle after the request");
        end
        rdata = wbs_dat_r;
        wbs_cyc <= 1'b0;
        wbs_stb <= 1'b0;
        wbs_we  <= 1'b0;
    endtask

    task automatic wait_irq(input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (interrupt !== level) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                fail_run("interrupt did not reach the expected level in time");
            end
        end
    endtask

    // One word per cycle through the preload port
    task automatic load_word(input int idx, input word_t data);
        @(posedge clk);
        ld_en  <= 1'b1;
        ld_adr <= addr_t'(idx) << 2;
        ld_dat <= data;
        shadow[idx] = data;
    endtask

    task automatic check_memory(input int c_word);
        for (int idx = 0; idx < MEM_WORDS; idx++) begin
            if (idx >= c_word && idx < c_word + N) begin
                check_acc($sformatf("C[%0d]", idx - c_word), acc_t'(u_mem.mem[idx]),
                          model_elem(idx - c_word));
            end else begin
                check_word($sformatf("mem[%0d]", idx), u_mem.mem[idx], shadow[idx]);
            end
        end
    endtask

    // Three distinct slots of N words each
    task automatic pick_bases(output int a_word, output int b_word, output int c_word);
        int half;
        int slot;
        half   = NUM_SLOTS / 2;
        slot   = {$random(seed)} % NUM_SLOTS;
        a_word = slot * N;
        b_word = ((slot + 1 + {$random(seed)} % (half - 1)) % NUM_SLOTS) * N;
        c_word = ((slot + half + {$random(seed)} % half) % NUM_SLOTS) * N;
    endtask

    task automatic run_once(input logic check_restart);
        int    a_word;
        int    b_word;
        int    c_word;
        word_t w;
        word_t rd;
        pick_bases(a_word, b_word, c_word);
        for (int k = 0; k < N; k++) begin
            // Only the low byte is an element and the upper bits are noise
            w = $random(seed);
            a_elem[k] = elem_t'(w[7:0]);
            load_word(a_word + k, w);
            w = $random(seed);
            b_elem[k] = elem_t'(w[7:0]);
            load_word(b_word + k, w);
        end
        @(posedge clk);
        ld_en <= 1'b0;

        reg_access(1'b1, REG_A_ADDR, addr_t'(a_word) << 2, rd);
        reg_access(1'b1, REG_B_ADDR, addr_t'(b_word) << 2, rd);
        reg_access(1'b1, REG_C_ADDR, addr_t'(c_word) << 2, rd);
        reg_access(1'b1, REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b0), rd);
        wait_irq(1'b1, RUN_LIMIT);
        check_memory(c_word);
        for (int k = 0; k < N; k++) begin
            shadow[c_word + k] = word_t'(model_elem(k));
        end
        reg_access(1'b0, REG_CTRL, '0, rd);
        check_word("ctrl", rd, ctrl_word(1'b1, 1'b1, 1'b0));

        if (check_restart) begin
            // Start already high in DONE, so no new run may begin
            reg_access(1'b1, REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b0), rd);
            for (int n = 0; n < QUIET_CYCLES; n++) begin
                @(posedge clk);
                if (interrupt !== 1'b1 || a_cyc || b_cyc || c_cyc) begin
                    fail_run("a second start write in the done state launched a run");
                end
            end
            check_memory(c_word);
        end

        reg_access(1'b1, REG_CTRL, ctrl_word(1'b0, 1'b0, 1'b0), rd);
        wait_irq(1'b0, FALL_LIMIT);
        reg_access(1'b0, REG_CTRL, '0, rd);
        check_word("ctrl", rd, ctrl_word(1'b0, 1'b0, 1'b1));
    endtask

    initial begin
        word_t    rd;
        word_t    base_vals [3];
        reg_adr_t base_regs [3];
        base_regs = '{REG_A_ADDR, REG_B_ADDR, REG_C_ADDR};
        rst       <= 1'b1;
        wbs_cyc   <= 1'b0;
        wbs_stb   <= 1'b0;
        wbs_we    <= 1'b0;
        wbs_adr   <= '0;
        wbs_dat_w <= '0;
        ld_en     <= 1'b0;
        ld_adr    <= '0;
        ld_dat    <= '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        for (int idx = 0; idx < MEM_WORDS; idx++) begin
            load_word(idx, fill_word(idx));
        end
        @(posedge clk);
        ld_en <= 1'b0;

        // Status after reset
        reg_access(1'b0, REG_CTRL, '0, rd);
        check_word("ctrl", rd, ctrl_word(1'b0, 1'b0, 1'b1));
        check_bit("interrupt", interrupt, 1'b0);
        foreach (base_regs[i]) begin
            base_vals[i] = $random(seed);
            reg_access(1'b1, base_regs[i], base_vals[i], rd);
        end
        // Status bits and unmapped offsets ignore writes
        reg_access(1'b1, REG_CTRL, ~ctrl_word(1'b1, 1'b0, 1'b0), rd);
        reg_access(1'b0, REG_CTRL, '0, rd);
        check_word("ctrl", rd, ctrl_word(1'b0, 1'b0, 1'b1));
        for (int off = 16; off < 32; off += 2) begin
            reg_access(1'b1, reg_adr_t'(off), 32'hffff_ffff, rd);
            reg_access(1'b0, reg_adr_t'(off), '0, rd);
            check_word($sformatf("unmapped 0x%02h", off), rd, '0);
        end
        foreach (base_regs[i]) begin
            reg_access(1'b0, base_regs[i], '0, rd);
            check_word($sformatf("base register 0x%02h", base_regs[i]), rd, base_vals[i]);
        end

        for (int r = 0; r < NUM_RUNS; r++) begin
            run_once(r == 0);
        end

        $display("Verification passed");
        $finish;
    end

endmodule
